//--- dsp16_core.f
source/dsp16_pkg.sv
source/dsp16_fetch.sv
source/dsp16_decode.sv
source/dsp16_ram_aau.sv
source/dsp16_dau.sv
source/dsp16_pio.sv
source/dsp16_core.sv
verif/dsp16_core_asserts.sv
verif/dsp16_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DSP16 core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f dsp16_core.f \
    --top-module dsp16_core_tb \
    -o dsp16_sim

sim_out=$(./obj_dir/dsp16_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "Regression passed"; then
    exit 0
else
    exit 1
fi

//--- source/dsp16_core.sv
// ****************************************
// DSP16 core top level
// Fetch, decode, RAM address unit,
// arithmetic unit and parallel output
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_core
    import dsp16_pkg::*;
#(
    parameter int ROM_AW = 12,
    parameter int RAM_AW = 10
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              clk_en,
    // ROM programming, byte addressed
    input  wire [ROM_AW:0]   prog_addr,
    input  wire [7:0]        prog_data,
    input  wire              prog_we,
    // Clock output, works as an enable
    output wire              cen_cko,
    // Parallel output
    output wire word_t       pbus_out,
    output wire              pods_n
);

    wire        cen;
    word_t      ir;
    wire        ir_valid;

    // Decoded strobes
    wire        jump, halt;
    wire        ptr_load, ram_store, ram_read;
    wire        x_load, y_load, mac_en, acc_clr;
    wire        out_en, acc_sel, out_hi;
    reg_field_t reg_field;
    imm_t       imm;

    // Data buses
    word_t      ram_dout;
    word_t      acc_out;

    assign cen_cko = cen;

    dsp16_fetch #(
        .ROM_AW     ( ROM_AW        )
    ) u_fetch (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .clk_en     ( clk_en        ),
        .prog_addr  ( prog_addr     ),
        .prog_data  ( prog_data     ),
        .prog_we    ( prog_we       ),
        .jump       ( jump          ),
        .halt       ( halt          ),
        .imm        ( imm           ),
        .cen        ( cen           ),
        .ir         ( ir            ),
        .ir_valid   ( ir_valid      )
    );

    dsp16_decode u_decode (
        .ir         ( ir            ),
        .ir_valid   ( ir_valid      ),
        .jump       ( jump          ),
        .halt       ( halt          ),
        .ptr_load   ( ptr_load      ),
        .ram_store  ( ram_store     ),
        .ram_read   ( ram_read      ),
        .x_load     ( x_load        ),
        .y_load     ( y_load        ),
        .mac_en     ( mac_en        ),
        .acc_clr    ( acc_clr       ),
        .out_en     ( out_en        ),
        .acc_sel    ( acc_sel       ),
        .out_hi     ( out_hi        ),
        .reg_field  ( reg_field     ),
        .imm        ( imm           )
    );

    dsp16_ram_aau #(
        .RAM_AW     ( RAM_AW        )
    ) u_ram_aau (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cen        ( cen           ),
        .ptr_load   ( ptr_load      ),
        .ram_store  ( ram_store     ),
        .ram_read   ( ram_read      ),
        .reg_field  ( reg_field     ),
        .imm        ( imm           ),
        .ram_dout   ( ram_dout      )
    );

    dsp16_dau u_dau (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cen        ( cen           ),
        .x_load     ( x_load        ),
        .y_load     ( y_load        ),
        .mac_en     ( mac_en        ),
        .acc_clr    ( acc_clr       ),
        .acc_sel    ( acc_sel       ),
        .out_hi     ( out_hi        ),
        .ram_dout   ( ram_dout      ),
        .acc_out    ( acc_out       )
    );

    dsp16_pio u_pio (
        .clk        ( clk           ),
        .reset      ( reset         ),
        .cen        ( cen           ),
        .out_en     ( out_en        ),
        .acc_out    ( acc_out       ),
        .pbus_out   ( pbus_out      ),
        .pods_n     ( pods_n        )
    );

endmodule

`default_nettype wire

//--- source/dsp16_dau.sv
// ****************************************
// DSP16 data arithmetic unit
// X and Y registers, signed 16x16
// multiply, two 36-bit accumulators
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_dau
    import dsp16_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              cen,
    // Strobes from decode
    input  wire              x_load,
    input  wire              y_load,
    input  wire              mac_en,
    input  wire              acc_clr,
    input  wire              acc_sel,
    input  wire              out_hi,
    input  wire word_t       ram_dout,
    // Selected accumulator half
    output word_t            acc_out
);

    word_t        x;
    word_t        y;
    acc_t [1:0]   acc;
    acc_t         acc_cur;
    prod_t        prod;
    acc_t         prod_ext;

    // Signed product, widened before the multiply
    assign prod     = PROD_W'($signed(x)) * PROD_W'($signed(y));
    assign prod_ext = {{(ACC_W-PROD_W){prod[PROD_W-1]}}, prod};

    assign acc_cur = acc[acc_sel];
    assign acc_out = out_hi ? acc_cur[2*WORD_W-1:WORD_W] : acc_cur[WORD_W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            x   <= '0;
            y   <= '0;
            acc <= '0;
        end else if (cen) begin
            if (x_load) begin
                x <= ram_dout;
            end
            if (y_load) begin
                y <= ram_dout;
            end
            // Accumulation wraps, no saturation
            if (acc_clr) begin
                acc[acc_sel] <= '0;
            end else if (mac_en) begin
                acc[acc_sel] <= acc_cur + prod_ext;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dsp16_decode.sv
// ****************************************
// DSP16 instruction decoder
// Splits the instruction register into
// per-unit strobes and operand fields
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_decode
    import dsp16_pkg::*;
(
    input  wire word_t       ir,
    input  wire              ir_valid,
    // Fetch control
    output logic             jump,
    output logic             halt,
    // RAM address unit
    output logic             ptr_load,
    output logic             ram_store,
    output logic             ram_read,
    // Arithmetic unit
    output logic             x_load,
    output logic             y_load,
    output logic             mac_en,
    output logic             acc_clr,
    // Output port
    output logic             out_en,
    output logic             acc_sel,
    output logic             out_hi,
    output reg_field_t       reg_field,
    output imm_t             imm
);

    opcode_t op;

    assign op        = ir[WORD_W-1 -: OP_W];
    assign reg_field = ir[IMM_W +: REG_W];
    assign imm       = ir[IMM_W-1:0];

    // Bit 0 picks the accumulator, bit 1 the output half
    assign acc_sel = reg_field[0];
    assign out_hi  = reg_field[1];

    always_comb begin
        jump      = 1'b0;
        halt      = 1'b0;
        ptr_load  = 1'b0;
        ram_store = 1'b0;
        ram_read  = 1'b0;
        x_load    = 1'b0;
        y_load    = 1'b0;
        mac_en    = 1'b0;
        acc_clr   = 1'b0;
        out_en    = 1'b0;
        if (ir_valid) begin
            case (op)
                OP_NOP: begin
                    // Nothing to do
                end
                OP_LDPTR: ptr_load  = 1'b1;
                OP_STIMM: ram_store = 1'b1;
                OP_LDX: begin
                    x_load   = 1'b1;
                    ram_read = 1'b1;
                end
                OP_LDY: begin
                    y_load   = 1'b1;
                    ram_read = 1'b1;
                end
                OP_MAC:  mac_en  = 1'b1;
                OP_CLR:  acc_clr = 1'b1;
                OP_OUT:  out_en  = 1'b1;
                OP_JMP:  jump    = 1'b1;
                OP_HALT: halt    = 1'b1;
                // Unassigned opcodes act as nop
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/dsp16_fetch.sv
// ****************************************
// DSP16 instruction fetch
// Halves clk_en into cen, holds the
// byte-programmed ROM, the program
// counter and the instruction register
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_fetch
    import dsp16_pkg::*;
#(
    parameter int ROM_AW = 12
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              clk_en,
    input  wire [ROM_AW:0]   prog_addr,
    input  wire [7:0]        prog_data,
    input  wire              prog_we,
    // From decode
    input  wire              jump,
    input  wire              halt,
    input  wire imm_t        imm,
    output logic             cen,
    output word_t            ir,
    output logic             ir_valid
);

    logic              div;
    logic [ROM_AW-1:0] pc;
    logic              fetch_en;
    run_state_e        state;
    word_t             rom [0:(2**ROM_AW)-1];

    // Divider flop toggles on each input enable
    always_ff @(posedge clk) begin
        if (reset) begin
            div <= 1'b0;
        end else if (clk_en) begin
            div <= ~div;
        end
    end

    assign cen = clk_en & div;

    // Programming port works regardless of cen
    // Even byte address is the low byte of the word
    always_ff @(posedge clk) begin
        if (prog_we) begin
            if (prog_addr[0]) begin
                rom[prog_addr[ROM_AW:1]][15:8] <= prog_data;
            end else begin
                rom[prog_addr[ROM_AW:1]][7:0] <= prog_data;
            end
        end
    end

    // A jump or halt in execute squashes this fetch
    assign fetch_en = (state == RUN) && !jump && !halt;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            state    <= RUN;
            ir_valid <= 1'b0;
        end else if (cen) begin
            ir_valid <= fetch_en;
            if (halt) begin
                state <= HALTED;
            end else if (jump) begin
                pc <= ROM_AW'(imm);
            end else if (state == RUN) begin
                pc <= pc + ROM_AW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && fetch_en) begin
            ir <= rom[pc];
        end
    end

endmodule

`default_nettype wire

//--- source/dsp16_pio.sv
// ****************************************
// DSP16 parallel output port
// Output data register and active-low
// pods_n strobe, one cen period long
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_pio
    import dsp16_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              cen,
    input  wire              out_en,
    input  wire word_t       acc_out,
    output word_t            pbus_out,
    output logic             pods_n
);

    // Strobe falls with the out instruction and rises on the next cen
    always_ff @(posedge clk) begin
        if (reset) begin
            pbus_out <= '0;
            pods_n   <= 1'b1;
        end else if (cen) begin
            pods_n <= ~out_en;
            if (out_en) begin
                pbus_out <= acc_out;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dsp16_pkg.sv
// ****************************************
// DSP16 core shared definitions
// Data and field widths, vector types,
// opcode constants and the fetch state
// ****************************************

`default_nettype none

package dsp16_pkg;

    // Field and data widths
    localparam int WORD_W = 16;
    localparam int PROD_W = 32;
    localparam int ACC_W  = 36;
    localparam int IMM_W  = 10;
    localparam int REG_W  = 2;
    localparam int OP_W   = 4;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [PROD_W-1:0] prod_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [IMM_W-1:0]  imm_t;
    typedef logic [REG_W-1:0]  reg_field_t;
    typedef logic [OP_W-1:0]   opcode_t;

    // Instruction word layout
    // opcode [15:12], register field [11:10], immediate [9:0]
    localparam opcode_t OP_NOP   = 4'h0;
    localparam opcode_t OP_LDPTR = 4'h1;
    localparam opcode_t OP_STIMM = 4'h2;
    localparam opcode_t OP_LDX   = 4'h3;
    localparam opcode_t OP_LDY   = 4'h4;
    localparam opcode_t OP_MAC   = 4'h5;
    localparam opcode_t OP_CLR   = 4'h6;
    localparam opcode_t OP_OUT   = 4'h7;
    localparam opcode_t OP_JMP   = 4'h8;
    localparam opcode_t OP_HALT  = 4'h9;

    // Fetch run state
    typedef enum logic {
        RUN,
        HALTED
    } run_state_e;

endpackage

`default_nettype wire

//--- source/dsp16_ram_aau.sv
// ****************************************
// DSP16 data RAM and address unit
// Four post-incremented pointers into
// an internal data RAM
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_ram_aau
    import dsp16_pkg::*;
#(
    parameter int RAM_AW = 10
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              cen,
    // Strobes from decode
    input  wire              ptr_load,
    input  wire              ram_store,
    input  wire              ram_read,
    input  wire reg_field_t  reg_field,
    input  wire imm_t        imm,
    // Read data to the arithmetic unit
    output word_t            ram_dout
);

    logic [3:0][RAM_AW-1:0] ptr;
    logic [RAM_AW-1:0]      addr;
    logic [RAM_AW-1:0]      addr_inc;
    word_t                  store_data;
    word_t                  ram [0:(2**RAM_AW)-1];

    assign addr     = ptr[reg_field];
    // Natural wrap at the top of the RAM
    assign addr_inc = addr + RAM_AW'(1);

    // Combinational read at the selected pointer
    assign ram_dout = ram[addr];

    // Stored immediate is sign extended
    assign store_data = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (cen) begin
            if (ptr_load) begin
                ptr[reg_field] <= RAM_AW'(imm);
            end else if (ram_store || ram_read) begin
                ptr[reg_field] <= addr_inc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen && ram_store) begin
            ram[addr] <= store_data;
        end
    end

endmodule

`default_nettype wire

//--- verif/dsp16_core_asserts.sv
// ****************************************
// DSP16 core protocol checks
// Strobe width, freeze and cen_cko rules,
// bound into the core top level
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_core_asserts
    import dsp16_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              clk_en,
    input  wire              cen_cko,
    input  wire word_t       pbus_out,
    input  wire              pods_n
);

    // Strobe is idle right after reset
    reset_idle: assert property (@(posedge clk) reset |=> pods_n)
        else $error("pods_n not high after reset");

    // First clock of a pulse never ends it
    pulse_min: assert property (@(posedge clk) disable iff (reset)
        $fell(pods_n) |=> !pods_n)
        else $error("pods_n pulse shorter than two clocks");

    // Second low clock with clk_en high ends the pulse
    pulse_max: assert property (@(posedge clk) disable iff (reset)
        (!pods_n && $past(!pods_n) && $past(pods_n, 2) && clk_en && $past(clk_en))
        |=> pods_n)
        else $error("pods_n pulse longer than two clocks");

    // Core frozen while clk_en is low
    freeze_stable: assert property (@(posedge clk) disable iff (reset)
        !clk_en |=> ($stable(pods_n) && $stable(pbus_out)))
        else $error("output moved while clk_en low");

    cen_half: assert property (@(posedge clk) disable iff (reset)
        cen_cko |=> !cen_cko)
        else $error("cen_cko high on two consecutive clocks");

endmodule

bind dsp16_core dsp16_core_asserts u_asserts (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .clk_en   ( clk_en   ),
    .cen_cko  ( cen_cko  ),
    .pbus_out ( pbus_out ),
    .pods_n   ( pods_n   )
);

`default_nettype wire

//--- verif/dsp16_core_tb.sv
// ****************************************
// DSP16 core testbench
// Builds small programs, loads them over
// the byte port, runs a software model
// and compares every pods_n strobe
// ****************************************

`timescale 1ns/10ps
`default_nettype none

module dsp16_core_tb
    import dsp16_pkg::*;
;

    logic        clk;
    logic        reset;
    logic        clk_en;
    logic [12:0] prog_addr;
    logic [7:0]  prog_data;
    logic        prog_we;
    logic        cen_cko;
    word_t       pbus_out;
    logic        pods_n;

    word_t       prog[$];
    word_t       exp_q[$];
    word_t       exp_w;
    int          strobes;
    int          errors;
    int          passed;
    int          failed;
    int          err_start;
    integer      seed;
    logic        pods_d;

    // Software model state
    logic [9:0]         mptr [0:3];
    word_t              mram [0:1023];
    logic signed [15:0] mx;
    logic signed [15:0] my;
    logic [35:0]        macc [0:1];

    dsp16_core #(.ROM_AW(12), .RAM_AW(10)) dut0 (
        .clk(clk), .reset(reset), .clk_en(clk_en),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_we(prog_we),
        .cen_cko(cen_cko), .pbus_out(pbus_out), .pods_n(pods_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Values sampled one clock after the strobe falls
    always @(posedge clk) begin
        if (!reset && pods_d && !pods_n) begin
            strobes++;
            if (exp_q.size() == 0) begin
                $display("Unexpected pods_n strobe at %0t", $time);
                errors++;
            end else begin
                exp_w = exp_q.pop_front();
                assert (pbus_out == exp_w) else begin
                    $display("** Error %0t: pbus_out %h, expected %h", $time, pbus_out, exp_w);
                    errors++;
                end
            end
        end
        pods_d = pods_n;
    end

    task automatic add_instr(input opcode_t op, input reg_field_t rf, input imm_t im);
        prog.push_back({op, rf, im});
    endtask

    function automatic imm_t rand_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[9:0];
    endfunction

    // Executes the program the way the ISA describes it
    task automatic run_model();
        int         pc;
        int         steps;
        bit         stop;
        word_t      w;
        opcode_t    op;
        reg_field_t rf;
        imm_t       im;
        logic signed [35:0] p;
        pc = 0;
        steps = 0;
        stop = 1'b0;
        for (int i = 0; i < 4; i++) mptr[i] = '0;
        mx = '0;
        my = '0;
        macc[0] = '0;
        macc[1] = '0;
        while (!stop && pc < prog.size() && steps < 1000) begin
            w = prog[pc];
            op = w[15:12];
            rf = w[11:10];
            im = w[9:0];
            pc++;
            steps++;
            case (op)
                OP_LDPTR: mptr[rf] = im;
                OP_STIMM: begin
                    mram[mptr[rf]] = {{6{im[9]}}, im};
                    mptr[rf] = mptr[rf] + 10'd1;
                end
                OP_LDX: begin
                    mx = mram[mptr[rf]];
                    mptr[rf] = mptr[rf] + 10'd1;
                end
                OP_LDY: begin
                    my = mram[mptr[rf]];
                    mptr[rf] = mptr[rf] + 10'd1;
                end
                OP_MAC: begin
                    p = 36'(mx) * 36'(my);
                    macc[rf[0]] = macc[rf[0]] + p;
                end
                OP_CLR:  macc[rf[0]] = '0;
                OP_OUT:  exp_q.push_back(rf[1] ? macc[rf[0]][31:16] : macc[rf[0]][15:0]);
                OP_JMP:  pc = int'(im);
                OP_HALT: stop = 1'b1;
                default: begin
                end
            endcase
        end
    endtask

    // Reset, byte load with clk_en low, then release the core
    task automatic start_run();
        @(posedge clk);
        #5;
        clk_en = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            for (int b = 0; b < 2; b++) begin
                prog_addr = 13'(2 * i + b);
                prog_data = (b == 1) ? prog[i][15:8] : prog[i][7:0];
                prog_we = 1'b1;
                @(posedge clk);
                #5;
            end
        end
        prog_we = 1'b0;
        clk_en = 1'b1;
    endtask

    task automatic wait_strobes(input int n, input int freeze_at);
        int cyc;
        cyc = 0;
        while (strobes < n && cyc < 400) begin
            @(posedge clk);
            #5;
            cyc++;
            if (cyc == freeze_at) clk_en = 1'b0;
            if (cyc == freeze_at + 12) clk_en = 1'b1;
        end
        if (strobes < n) begin
            $display("Timeout: saw %0d of %0d strobes", strobes, n);
            errors++;
        end
        clk_en = 1'b1;
        // Quiet window, catches strobes after halt
        repeat (30) @(posedge clk);
        #5;
    endtask

    task automatic new_test();
        prog.delete();
        exp_q.delete();
        strobes = 0;
        err_start = errors;
    endtask

    task automatic run_test(input string name, input int freeze_at);
        int n;
        run_model();
        n = exp_q.size();
        start_run();
        wait_strobes(n, freeze_at);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected strobes never came", name, exp_q.size());
            errors++;
        end
        if (errors == err_start) begin
            $display("PASS %s (%0d strobes)", name, strobes);
            passed++;
        end else begin
            $display("FAIL %s", name);
            failed++;
        end
    endtask

    task automatic build_dot();
        add_instr(OP_CLR, 2'd0, '0);
        add_instr(OP_LDPTR, 2'd0, 10'h010);
        for (int i = 0; i < 8; i++) add_instr(OP_STIMM, 2'd0, rand_imm());
        add_instr(OP_LDPTR, 2'd1, 10'h010);
        for (int i = 0; i < 4; i++) begin
            add_instr(OP_LDX, 2'd1, '0);
            add_instr(OP_LDY, 2'd1, '0);
            add_instr(OP_MAC, 2'd0, '0);
        end
        add_instr(OP_OUT, 2'd0, '0);
        add_instr(OP_NOP, 2'd0, '0);
        add_instr(OP_OUT, 2'd2, '0);
        add_instr(OP_HALT, 2'd0, '0);
    endtask

    initial begin
        seed = 32'hb696_6861;
        reset = 1'b1;
        clk_en = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_we = 1'b0;
        pods_d = 1'b1;
        errors = 0;
        passed = 0;
        failed = 0;

        // Reset state, outputs idle until the first out
        new_test();
        add_instr(OP_CLR, 2'd0, '0);
        repeat (3) add_instr(OP_NOP, 2'd0, '0);
        add_instr(OP_OUT, 2'd0, '0);
        add_instr(OP_HALT, 2'd0, '0);
        start_run();
        repeat (4) begin
            @(posedge clk);
            assert (pods_n === 1'b1 && pbus_out === 16'h0000) else begin
                $display("** Error %0t: outputs not idle after reset", $time);
                errors++;
            end
        end
        run_test("reset_state", 0);

        new_test();
        build_dot();
        run_test("dot_product", 0);

        // Accumulators used alternately, one cleared
        new_test();
        add_instr(OP_LDPTR, 2'd2, 10'h020);
        repeat (3) add_instr(OP_STIMM, 2'd2, rand_imm());
        add_instr(OP_LDPTR, 2'd2, 10'h020);
        add_instr(OP_LDX, 2'd2, '0);
        add_instr(OP_LDY, 2'd2, '0);
        add_instr(OP_MAC, 2'd0, '0);
        add_instr(OP_MAC, 2'd1, '0);
        add_instr(OP_MAC, 2'd1, '0);
        add_instr(OP_LDX, 2'd2, '0);
        add_instr(OP_CLR, 2'd0, '0);
        add_instr(OP_MAC, 2'd0, '0);
        add_instr(OP_OUT, 2'd0, '0);
        add_instr(OP_NOP, 2'd0, '0);
        add_instr(OP_OUT, 2'd1, '0);
        add_instr(OP_NOP, 2'd0, '0);
        add_instr(OP_OUT, 2'd3, '0);
        add_instr(OP_HALT, 2'd0, '0);
        run_test("accumulators", 0);

        // Jump over an out, slot after jmp discarded
        new_test();
        add_instr(OP_LDPTR, 2'd3, 10'h040);
        add_instr(OP_STIMM, 2'd3, rand_imm());
        add_instr(OP_STIMM, 2'd3, rand_imm());
        add_instr(OP_LDPTR, 2'd3, 10'h040);
        add_instr(OP_LDX, 2'd3, '0);
        add_instr(OP_LDY, 2'd3, '0);
        add_instr(OP_MAC, 2'd1, '0);
        add_instr(OP_JMP, 2'd0, imm_t'(prog.size() + 3));
        add_instr(OP_OUT, 2'd1, '0);
        add_instr(OP_OUT, 2'd3, '0);
        add_instr(OP_NOP, 2'd0, '0);
        add_instr(OP_OUT, 2'd1, '0);
        add_instr(OP_NOP, 2'd0, '0);
        add_instr(OP_OUT, 2'd3, '0);
        add_instr(OP_HALT, 2'd0, '0);
        run_test("jump", 0);

        // More out instructions sit behind the halt
        new_test();
        add_instr(OP_CLR, 2'd0, '0);
        add_instr(OP_OUT, 2'd0, '0);
        add_instr(OP_HALT, 2'd0, '0);
        add_instr(OP_OUT, 2'd0, '0);
        add_instr(OP_NOP, 2'd0, '0);
        add_instr(OP_OUT, 2'd2, '0);
        add_instr(OP_HALT, 2'd0, '0);
        run_test("halt", 0);

        // Freeze starts while the first dot product strobe is low
        new_test();
        build_dot();
        run_test("freeze", 50);

        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
